// File: include/fetch_config.svh
// Fetch queue depth, RAM size and word address width
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Queue entries, 4 or 8
`define FQ_DEPTH 4

// 64-bit RAM words; block numbers at or above this fault
`define MEM_WORDS 64

`define MEM_ADDR_W 6

`endif

// File: rtl/fetch_pkg.sv
// Fetch-side types for parcels, instructions, blocks, parcel masks and fetch addresses
package fetch_pkg;

    // One 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // Issued instruction, 16-bit ones sit in the low half
    typedef logic [31:0] inst_t;

    // Four parcels, parcel 0 in bits 15:0
    typedef logic [63:0] fetch_block_t;

    // One bit per parcel of a block
    typedef logic [3:0] parcel_mask_t;

    // Parcel address: block number in 15:2, start parcel in 1:0
    typedef logic [15:0] fetch_addr_t;

endpackage

// File: rtl/mem_pkg.sv
// Memory-side types for word address, data word and arbiter state
`include "fetch_config.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    typedef logic [63:0] mem_data_t;

    // Owner of the RAM read that returns next cycle
    typedef enum logic [1:0] {
        arb_idle,
        arb_fetch_read,
        arb_load_read
    } arb_state_e;

endpackage

// File: rtl/block_ram.sv
// Single-port 64-bit block RAM with preload write and registered read
`timescale 1ns/100ps
`include "fetch_config.svh"

module block_ram (
    input  logic               core_clk,
    input  logic               core_reset_n,
    input  logic               preload_wr,
    input  mem_pkg::mem_addr_t preload_addr,
    input  mem_pkg::mem_data_t preload_data,
    input  logic               ram_en,
    input  mem_pkg::mem_addr_t ram_addr,
    output mem_pkg::mem_data_t ram_rdata
);
    import mem_pkg::*;

    mem_data_t mem [`MEM_WORDS];

    always_ff @(posedge core_clk) begin
        if (preload_wr) begin
            mem[preload_addr] <= preload_data;
        end
    end

    // Preload owns the port while it writes
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            ram_rdata <= '0;
        end else if (ram_en && !preload_wr) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// File: rtl/mem_arbiter.sv
// RAM arbiter between fetch and load requesters with read data return and range check
`timescale 1ns/100ps
`include "fetch_config.svh"

module mem_arbiter (
    input  logic                  core_clk,
    input  logic                  core_reset_n,
    input  logic                  fetch_req,
    input  fetch_pkg::fetch_addr_t fetch_addr,
    output logic                  fetch_gnt,
    output logic                  fetch_rvalid,
    output logic                  fetch_fault,
    input  logic                  load_req,
    input  mem_pkg::mem_addr_t    load_addr,
    output logic                  load_gnt,
    output logic                  load_done,
    output mem_pkg::mem_data_t    load_data,
    output mem_pkg::mem_data_t    rdata,
    output logic                  ram_en,
    output mem_pkg::mem_addr_t    ram_addr,
    input  mem_pkg::mem_data_t    ram_rdata
);
    import mem_pkg::*;

    arb_state_e state;
    logic       load_pend;
    mem_addr_t  load_addr_q;
    logic       fair_load;
    logic       oob_q;
    logic       fetch_oob;
    logic       load_want;
    mem_addr_t  load_addr_sel;
    logic       load_win;
    logic       fetch_win;

    assign load_want     = load_req | load_pend;          // Load pulse waits here if it loses
    assign load_addr_sel = load_pend ? load_addr_q : load_addr;
    assign fetch_oob     = (fetch_addr[15:2] >= 14'(`MEM_WORDS));

    // Load wins ties unless it won last time while fetch was waiting
    assign load_win  = load_want & ~(fetch_req & fair_load);
    assign fetch_win = fetch_req & ~load_win;

    assign fetch_gnt = fetch_win;
    assign load_gnt  = load_win;
    assign ram_en    = load_win | (fetch_win & ~fetch_oob); // No RAM cycle for a faulting block
    assign ram_addr  = load_win ? load_addr_sel : fetch_addr[`MEM_ADDR_W+1:2];

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state     <= arb_idle;
            load_pend <= 1'b0;
            fair_load <= 1'b0;
            oob_q     <= 1'b0;
        end else begin
            state     <= load_win ? arb_load_read :
                         fetch_win ? arb_fetch_read : arb_idle;
            load_pend <= load_want & ~load_win;
            fair_load <= load_win & fetch_req;
            oob_q     <= fetch_win & fetch_oob;
        end
    end

    always_ff @(posedge core_clk) begin
        if (load_req) begin
            load_addr_q <= load_addr;
        end
    end

    assign fetch_rvalid = (state == arb_fetch_read);
    assign fetch_fault  = fetch_rvalid & oob_q;
    assign load_done    = (state == arb_load_read);
    assign load_data    = ram_rdata;
    assign rdata        = ram_rdata;

endmodule

// File: rtl/fetch_gen.sv
// Fetch generator with block addressing, queue credits and block write into the fetch queue
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_gen (
    input  logic                    core_clk,
    input  logic                    core_reset_n,
    input  logic                    fetch_kill,
    input  fetch_pkg::fetch_addr_t  redirect_pc,
    output logic                    fetch_req,
    output fetch_pkg::fetch_addr_t  fetch_addr,
    input  logic                    fetch_gnt,
    input  logic                    fetch_rvalid,
    input  logic                    fetch_fault,
    input  mem_pkg::mem_data_t      rdata,
    output logic                    fq_wr,
    output fetch_pkg::parcel_mask_t fq_wr_valid,
    output fetch_pkg::fetch_block_t fq_wr_inst,
    output logic                    fq_wr_bblk_start,
    output fetch_pkg::parcel_mask_t fq_wr_xcpt,
    input  logic                    fq_rd
);
    import fetch_pkg::*;

    localparam int credit_w = $clog2(`FQ_DEPTH) + 1;

    logic                active;
    fetch_addr_t         next_addr;
    logic [credit_w-1:0] credits;
    logic                first_blk;
    logic                drop;
    logic                infl_first;
    parcel_mask_t        infl_mask;
    parcel_mask_t        gnt_mask;

    // Idle after reset until a redirect supplies a pc
    assign fetch_req  = active & (credits != '0);
    assign fetch_addr = next_addr;

    // First block after a redirect starts at the redirect parcel
    assign gnt_mask = first_blk ? (4'b1111 << next_addr[1:0]) : 4'b1111;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            active    <= 1'b0;
            next_addr <= '0;
            credits   <= credit_w'(`FQ_DEPTH);
            first_blk <= 1'b0;
            drop      <= 1'b0;
        end else if (fetch_kill) begin
            active    <= 1'b1;
            next_addr <= redirect_pc;
            credits   <= credit_w'(`FQ_DEPTH);
            first_blk <= 1'b1;
            drop      <= fetch_gnt;                          // Read granted now returns stale
        end else begin
            drop    <= 1'b0;
            credits <= credits - credit_w'(fetch_gnt) + credit_w'(fq_rd);
            if (fetch_gnt) begin
                next_addr <= {next_addr[15:2] + 14'd1, 2'b00};
                first_blk <= 1'b0;
            end
        end
    end

    // Attributes of the read in flight, used when it returns next cycle
    always_ff @(posedge core_clk) begin
        if (fetch_gnt) begin
            infl_first <= first_blk;
            infl_mask  <= gnt_mask;
        end
    end

    assign fq_wr            = fetch_rvalid & ~drop;
    assign fq_wr_valid      = infl_mask;
    assign fq_wr_inst       = fetch_fault ? '0 : rdata;
    assign fq_wr_bblk_start = infl_first;
    assign fq_wr_xcpt       = fetch_fault ? infl_mask : '0; // Every valid parcel takes the fault

endmodule

// File: rtl/fetch_queue.sv
// Fetch queue with block storage, parcel residue and a two-slot instruction aligner
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_queue (
    input  logic                    core_clk,
    input  logic                    core_reset_n,
    input  logic                    fetch_kill,
    input  logic                    fq_wr,
    input  fetch_pkg::parcel_mask_t fq_wr_valid,
    input  fetch_pkg::fetch_block_t fq_wr_inst,
    input  logic                    fq_wr_bblk_start,
    input  fetch_pkg::parcel_mask_t fq_wr_xcpt,
    output logic                    fq_rd,
    output logic                    i0_valid,
    output fetch_pkg::inst_t        i0_inst,
    output logic                    i0_bblk_start,
    output logic                    i0_xcpt,
    output logic                    i0_xcpt_upper,
    input  logic                    i0_ready,
    output logic                    i1_valid,
    output fetch_pkg::inst_t        i1_inst,
    output logic                    i1_xcpt,
    output logic                    i1_xcpt_upper,
    input  logic                    i1_ready
);
    import fetch_pkg::*;

    localparam int ptr_w = $clog2(`FQ_DEPTH);

    fetch_block_t         blk_data  [`FQ_DEPTH];
    parcel_mask_t         blk_valid [`FQ_DEPTH];
    parcel_mask_t         blk_xcpt  [`FQ_DEPTH];
    logic [`FQ_DEPTH-1:0] blk_bblk;
    logic [ptr_w:0]       wr_ptr;
    logic [ptr_w:0]       rd_ptr;
    logic [ptr_w-1:0]     rd_idx;

    // Residue keeps up to three leftover parcels, oldest in the low bits
    logic [47:0]  res_data;
    logic [2:0]   res_x;
    logic         res_bblk;
    logic [1:0]   res_cnt;
    logic [47:0]  res_keep;
    logic [2:0]   res_xkeep;

    logic         head_vld;
    parcel_mask_t head_mask;
    logic [1:0]   h_start;
    logic [2:0]   h_cnt;
    fetch_block_t head_seq;
    parcel_mask_t head_xs;

    logic [111:0] win_data;
    logic [6:0]   win_x;
    logic [6:0]   win_b;
    logic [2:0]   win_cnt;
    logic [111:0] win_shift;
    logic [6:0]   x_shift;
    logic [6:0]   b_shift;

    parcel_t      p0, p1, p2, p3;
    parcel_t      q0, q1;
    logic         len0_32, len1_32;
    logic         x0, x1;
    logic [2:0]   len0, need1;
    logic         i0_fire, i1_fire;
    logic [2:0]   consumed, remaining;
    logic         pop;

    assign head_vld  = (wr_ptr != rd_ptr);
    assign rd_idx    = rd_ptr[ptr_w-1:0];
    assign head_mask = head_vld ? blk_valid[rd_idx] : '0;

    // Valid parcels are always the upper ones of a block
    assign h_start  = head_mask[0] ? 2'd0 : head_mask[1] ? 2'd1 : head_mask[2] ? 2'd2 : 2'd3;
    assign h_cnt    = 3'($countones(head_mask));
    assign head_seq = head_vld ? (blk_data[rd_idx] >> (16 * h_start)) : '0;
    assign head_xs  = (blk_xcpt[rd_idx] & head_mask) >> h_start;

    // Window is the residue followed by the head block parcels
    assign res_keep  = (48'd1 << (16 * res_cnt)) - 48'd1;
    assign res_xkeep = (3'd1 << res_cnt) - 3'd1;
    assign win_data  = ({48'd0, head_seq} << (16 * res_cnt)) | {64'd0, res_data & res_keep};
    assign win_x     = ({3'd0, head_xs} << res_cnt) | {4'd0, res_x & res_xkeep};
    assign win_b     = ({6'd0, head_vld & blk_bblk[rd_idx]} << res_cnt)
                     | {6'd0, res_bblk & (res_cnt != 2'd0)};
    assign win_cnt   = {1'b0, res_cnt} + h_cnt;

    assign p0 = win_data[15:0];
    assign p1 = win_data[31:16];
    assign p2 = win_data[47:32];
    assign p3 = win_data[63:48];

    assign len0_32 = &p0[1:0];                              // Both length bits set is 32-bit
    assign len0    = len0_32 ? 3'd2 : 3'd1;
    assign q0      = len0_32 ? p2 : p1;
    assign q1      = len0_32 ? p3 : p2;
    assign x0      = len0_32 ? win_x[2] : win_x[1];
    assign x1      = len0_32 ? win_x[3] : win_x[2];
    assign len1_32 = &q0[1:0];
    assign need1   = len0 + (len1_32 ? 3'd2 : 3'd1);

    assign i0_valid      = (win_cnt >= len0);
    assign i0_inst       = len0_32 ? {p1, p0} : {16'h0000, p0};
    assign i0_xcpt       = win_x[0] | (len0_32 & win_x[1]);
    assign i0_xcpt_upper = ~win_x[0] & len0_32 & win_x[1];
    assign i0_bblk_start = win_b[0];

    assign i1_valid      = i0_valid & ~i0_xcpt & (win_cnt >= need1); // Stop behind a fault
    assign i1_inst       = len1_32 ? {q1, q0} : {16'h0000, q0};
    assign i1_xcpt       = x0 | (len1_32 & x1);
    assign i1_xcpt_upper = ~x0 & len1_32 & x1;

    assign i0_fire   = i0_valid & i0_ready;
    assign i1_fire   = i1_valid & i1_ready & i0_ready;      // i1 only goes with i0
    assign consumed  = i1_fire ? need1 : i0_fire ? len0 : 3'd0;
    assign remaining = win_cnt - consumed;

    // Head moves into the residue once what is left of the window fits there
    assign pop   = head_vld & (remaining <= 3'd3);
    assign fq_rd = pop;

    assign win_shift = win_data >> (16 * consumed);
    assign x_shift   = win_x >> consumed;
    assign b_shift   = win_b >> consumed;

    always_ff @(posedge core_clk) begin
        if (fq_wr && !fetch_kill) begin
            blk_data[wr_ptr[ptr_w-1:0]]  <= fq_wr_inst;
            blk_valid[wr_ptr[ptr_w-1:0]] <= fq_wr_valid;
            blk_xcpt[wr_ptr[ptr_w-1:0]]  <= fq_wr_xcpt;
            blk_bblk[wr_ptr[ptr_w-1:0]]  <= fq_wr_bblk_start;
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            res_cnt <= 2'd0;
        end else if (fetch_kill) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            res_cnt <= 2'd0;
        end else begin
            wr_ptr  <= wr_ptr + (ptr_w+1)'(fq_wr);
            rd_ptr  <= rd_ptr + (ptr_w+1)'(pop);
            res_cnt <= pop ? remaining[1:0] : res_cnt - consumed[1:0]; // No pop, head untouched
        end
    end

    always_ff @(posedge core_clk) begin
        res_data <= win_shift[47:0];
        res_x    <= x_shift[2:0];
        res_bblk <= b_shift[0];
    end

endmodule

// File: rtl/fetch_top.sv
// Fetch subsystem top with block RAM, memory arbiter, fetch generator and fetch queue
`timescale 1ns/100ps

module fetch_top (
    input  logic                   core_clk,
    input  logic                   core_reset_n,
    input  logic                   preload_wr,
    input  mem_pkg::mem_addr_t     preload_addr,
    input  mem_pkg::mem_data_t     preload_data,
    input  logic                   fetch_kill,
    input  fetch_pkg::fetch_addr_t redirect_pc,
    output logic                   i0_valid,
    output fetch_pkg::inst_t       i0_inst,
    output logic                   i0_bblk_start,
    output logic                   i0_xcpt,
    output logic                   i0_xcpt_upper,
    input  logic                   i0_ready,
    output logic                   i1_valid,
    output fetch_pkg::inst_t       i1_inst,
    output logic                   i1_xcpt,
    output logic                   i1_xcpt_upper,
    input  logic                   i1_ready,
    input  logic                   load_req,
    input  mem_pkg::mem_addr_t     load_addr,
    output logic                   load_done,
    output mem_pkg::mem_data_t     load_data
);
    import fetch_pkg::*;
    import mem_pkg::*;

    logic         ram_en;
    mem_addr_t    ram_addr;
    mem_data_t    ram_rdata;
    logic         fetch_req;
    fetch_addr_t  fetch_addr;
    logic         fetch_gnt;
    logic         fetch_rvalid;
    logic         fetch_fault;
    mem_data_t    rdata;
    logic         fq_wr;
    parcel_mask_t fq_wr_valid;
    fetch_block_t fq_wr_inst;
    logic         fq_wr_bblk_start;
    parcel_mask_t fq_wr_xcpt;
    logic         fq_rd;

    block_ram u_ram (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .preload_wr   (preload_wr),
        .preload_addr (preload_addr),
        .preload_data (preload_data),
        .ram_en       (ram_en),
        .ram_addr     (ram_addr),
        .ram_rdata    (ram_rdata)
    );

    // Load grant is internal to the arbiter, completion comes back as load_done
    mem_arbiter u_arb (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_gnt    (fetch_gnt),
        .fetch_rvalid (fetch_rvalid),
        .fetch_fault  (fetch_fault),
        .load_req     (load_req),
        .load_addr    (load_addr),
        .load_gnt     (),
        .load_done    (load_done),
        .load_data    (load_data),
        .rdata        (rdata),
        .ram_en       (ram_en),
        .ram_addr     (ram_addr),
        .ram_rdata    (ram_rdata)
    );

    fetch_gen u_gen (
        .core_clk         (core_clk),
        .core_reset_n     (core_reset_n),
        .fetch_kill       (fetch_kill),
        .redirect_pc      (redirect_pc),
        .fetch_req        (fetch_req),
        .fetch_addr       (fetch_addr),
        .fetch_gnt        (fetch_gnt),
        .fetch_rvalid     (fetch_rvalid),
        .fetch_fault      (fetch_fault),
        .rdata            (rdata),
        .fq_wr            (fq_wr),
        .fq_wr_valid      (fq_wr_valid),
        .fq_wr_inst       (fq_wr_inst),
        .fq_wr_bblk_start (fq_wr_bblk_start),
        .fq_wr_xcpt       (fq_wr_xcpt),
        .fq_rd            (fq_rd)
    );

    fetch_queue u_fq (
        .core_clk         (core_clk),
        .core_reset_n     (core_reset_n),
        .fetch_kill       (fetch_kill),
        .fq_wr            (fq_wr),
        .fq_wr_valid      (fq_wr_valid),
        .fq_wr_inst       (fq_wr_inst),
        .fq_wr_bblk_start (fq_wr_bblk_start),
        .fq_wr_xcpt       (fq_wr_xcpt),
        .fq_rd            (fq_rd),
        .i0_valid         (i0_valid),
        .i0_inst          (i0_inst),
        .i0_bblk_start    (i0_bblk_start),
        .i0_xcpt          (i0_xcpt),
        .i0_xcpt_upper    (i0_xcpt_upper),
        .i0_ready         (i0_ready),
        .i1_valid         (i1_valid),
        .i1_inst          (i1_inst),
        .i1_xcpt          (i1_xcpt),
        .i1_xcpt_upper    (i1_xcpt_upper),
        .i1_ready         (i1_ready)
    );

endmodule

// File: verif/fetch_tb.sv
// Testbench for the fetch subsystem with RAM preload, reference aligner, run table and watchdog
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;
    import mem_pkg::*;

    logic        core_clk;
    logic        core_reset_n;
    logic        preload_wr;
    mem_addr_t   preload_addr;
    mem_data_t   preload_data;
    logic        fetch_kill;
    fetch_addr_t redirect_pc;
    logic        i0_valid;
    inst_t       i0_inst;
    logic        i0_bblk_start;
    logic        i0_xcpt;
    logic        i0_xcpt_upper;
    logic        i0_ready;
    logic        i1_valid;
    inst_t       i1_inst;
    logic        i1_xcpt;
    logic        i1_xcpt_upper;
    logic        i1_ready;
    logic        load_req;
    mem_addr_t   load_addr;
    logic        load_done;
    mem_data_t   load_data;

    parcel_t     img [4*`MEM_WORDS];                          // Parcel image of the whole RAM
    logic [31:0] lcg_state;
    inst_t       exp_inst [64];
    logic [31:0] exp_mask [64];                               // Bits of inst that are defined
    logic        exp_x [64];
    logic        exp_up [64];
    int          n_exp;
    int          idx;
    int          row_pc [16];
    int          row_cnt [16];
    logic [7:0]  row_rdy0 [16];
    logic [7:0]  row_rdy1 [16];
    logic        row_ld [16];
    int          row_ld_addr [16];
    int          n_rows = 0;
    logic        table_done = 1'b0;
    int          wd_cycles;
    int          errors = 0;
    int          i;

    fetch_top dut0 (.*);

    always #50 core_clk = ~core_clk;

    function automatic parcel_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic mem_data_t word_of(input int w);
        return {img[4*w+3], img[4*w+2], img[4*w+1], img[4*w]};
    endfunction

    // Aligns the parcel stream from pc, ending early at the first faulting instruction
    function automatic void build_expected(input int pc, input int count);
        int      a;
        logic    stop;
        logic    fhi;
        parcel_t lo;
        parcel_t hi;
        a = pc;
        stop = 1'b0;
        n_exp = 0;
        while (n_exp < count && !stop) begin
            exp_mask[n_exp] = 32'hffff_ffff;
            exp_x[n_exp] = 1'b0;
            exp_up[n_exp] = 1'b0;
            if (a / 4 >= `MEM_WORDS) begin
                exp_inst[n_exp] = '0;
                exp_mask[n_exp] = '0;
                exp_x[n_exp] = 1'b1;
                stop = 1'b1;
            end else begin
                lo = img[a];
                if (lo[1:0] == 2'b11) begin                   // 32-bit one that may cross a block
                    fhi = ((a + 1) / 4 >= `MEM_WORDS);
                    hi = fhi ? 16'h0000 : img[a+1];
                    exp_inst[n_exp] = {hi, lo};
                    if (fhi) begin
                        exp_mask[n_exp] = 32'h0000_ffff;
                        exp_x[n_exp] = 1'b1;
                        exp_up[n_exp] = 1'b1;
                        stop = 1'b1;
                    end
                    a = a + 2;
                end else begin
                    exp_inst[n_exp] = {16'h0000, lo};
                    a = a + 1;
                end
            end
            n_exp++;
        end
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_issue(input int r, input string slot, input inst_t inst,
                               input logic x, input logic up);
        string tag;
        tag = $sformatf("row %0d %s #%0d", r, slot, idx);
        check_value({tag, " inst"}, inst & exp_mask[idx], exp_inst[idx] & exp_mask[idx]);
        check_value({tag, " xcpt"}, x, exp_x[idx]);
        check_value({tag, " xcpt_upper"}, up, exp_up[idx]);
    endtask

    task automatic add_row(input int pc, input int count, input logic [7:0] rdy0,
                           input logic [7:0] rdy1, input logic ld, input int ld_addr);
        row_pc[n_rows] = pc;
        row_cnt[n_rows] = count;
        row_rdy0[n_rows] = rdy0;
        row_rdy1[n_rows] = rdy1;
        row_ld[n_rows] = ld;
        row_ld_addr[n_rows] = ld_addr;
        n_rows++;
    endtask

    // Redirects to the row pc, then consumes and checks the expected stream at falling edges
    task automatic run_row(input int r);
        int          cyc;
        int          ld_wait;
        logic        ld_busy;
        logic        ld_todo;
        logic        rdy0;
        logic        rdy1;
        logic        fire0;
        logic        fire1;
        logic        hold0;
        logic        hold1;
        logic [35:0] prev0;
        logic [34:0] prev1;
        build_expected(row_pc[r], row_cnt[r]);
        fetch_kill = 1'b1;
        redirect_pc = fetch_addr_t'(row_pc[r]);
        i0_ready = 1'b0;
        i1_ready = 1'b0;
        load_req = 1'b0;
        @(negedge core_clk);
        fetch_kill = 1'b0;
        idx = 0;
        cyc = 0;
        ld_wait = 0;
        ld_busy = 1'b0;
        ld_todo = row_ld[r];
        hold0 = 1'b0;
        hold1 = 1'b0;
        while (idx < n_exp || ld_busy || ld_todo) begin
            check_value("i1_valid only with i0_valid", i1_valid & ~i0_valid, 1'b0);
            if (hold0) begin
                check_value($sformatf("row %0d i0 held under back-pressure", r),
                            {i0_valid, i0_bblk_start, i0_xcpt, i0_xcpt_upper, i0_inst},
                            prev0);
            end
            if (hold1) begin
                check_value($sformatf("row %0d i1 held under back-pressure", r),
                            {i1_valid, i1_xcpt, i1_xcpt_upper, i1_inst}, prev1);
            end
            if (ld_busy && load_done) begin
                check_value($sformatf("row %0d load data", r), load_data,
                            word_of(row_ld_addr[r]));
                ld_busy = 1'b0;
            end else if (ld_busy) begin
                ld_wait++;
                check_value("load_done within 3 cycles", ld_wait < 3, 1'b1);
            end else begin
                check_value("load_done without a load", load_done, 1'b0);
            end
            rdy0 = row_rdy0[r][cyc % 8] && (idx < n_exp);
            rdy1 = row_rdy1[r][cyc % 8] && (idx + 1 < n_exp); // Never take past the row end
            i0_ready = rdy0;
            i1_ready = rdy1;
            fire0 = i0_valid && rdy0;
            fire1 = fire0 && i1_valid && rdy1;
            if (fire0) begin
                check_value($sformatf("row %0d bblk_start #%0d", r, idx), i0_bblk_start,
                            idx == 0);
                check_issue(r, "i0", i0_inst, i0_xcpt, i0_xcpt_upper);
                idx++;
            end
            if (fire1) begin
                check_issue(r, "i1", i1_inst, i1_xcpt, i1_xcpt_upper);
                idx++;
            end
            hold0 = i0_valid && !fire0;
            hold1 = i1_valid && !fire0;
            prev0 = {i0_valid, i0_bblk_start, i0_xcpt, i0_xcpt_upper, i0_inst};
            prev1 = {i1_valid, i1_xcpt, i1_xcpt_upper, i1_inst};
            if (ld_todo && cyc >= 4) begin
                load_req = 1'b1;
                load_addr = mem_addr_t'(row_ld_addr[r]);
                ld_busy = 1'b1;
                ld_todo = 1'b0;
                ld_wait = 0;
            end else begin
                load_req = 1'b0;
            end
            cyc++;
            @(negedge core_clk);
        end
    endtask

    initial begin
        core_clk = 1'b0;
        core_reset_n = 1'b0;
        preload_wr = 1'b0;
        preload_addr = '0;
        preload_data = '0;
        fetch_kill = 1'b0;
        redirect_pc = '0;
        i0_ready = 1'b0;
        i1_ready = 1'b0;
        load_req = 1'b0;
        load_addr = '0;
        lcg_state = 32'd95;
        for (i = 0; i < 4*`MEM_WORDS; i++) begin
            img[i] = lcg_next();
        end
        img[4*`MEM_WORDS-1][1:0] = 2'b11;                     // Last parcel opens a 32-bit inst
        add_row(0, 40, 8'hff, 8'hff, 1'b0, 0);
        add_row(13, 30, 8'hf7, 8'h5b, 1'b1, 9);
        add_row(70, 24, 8'h0f, 8'hff, 1'b0, 0);               // Four stall cycles in eight
        add_row(130, 6, 8'hff, 8'hff, 1'b0, 0);               // Next kill hits a full queue
        add_row(201, 30, 8'hff, 8'haa, 1'b1, 40);
        add_row(244, 30, 8'hff, 8'hff, 1'b0, 0);              // Runs off the end of memory
        add_row(255, 1, 8'hff, 8'hff, 1'b0, 0);
        add_row(300, 1, 8'hff, 8'hff, 1'b0, 0);
        add_row(2, 20, 8'h81, 8'h81, 1'b1, 63);
        table_done = 1'b1;
        repeat (2) @(posedge core_clk);
        @(negedge core_clk);
        core_reset_n = 1'b1;
        for (i = 0; i < `MEM_WORDS; i++) begin
            preload_wr = 1'b1;
            preload_addr = mem_addr_t'(i);
            preload_data = word_of(i);
            @(negedge core_clk);
        end
        preload_wr = 1'b0;
        for (i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        wd_cycles = 200;
        for (int k = 0; k < n_rows; k++) begin
            wd_cycles = wd_cycles + row_cnt[k] * 20;
        end
        repeat (wd_cycles) @(posedge core_clk);
        $display("Watchdog expired after %0d cycles with instructions or a load outstanding",
                 wd_cycles);
        $display("Checks failed");
        $fatal(1);
    end

endmodule

// File: list.f
+incdir+include
rtl/fetch_pkg.sv
rtl/mem_pkg.sv
rtl/block_ram.sv
rtl/mem_arbiter.sv
rtl/fetch_gen.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verif/fetch_tb.sv
